// ==== Bender.yml ====
package:
  name: ecc_mem

sources:
  - files:
      - hw/ecc_pkg.sv
      - hw/ecc_76_cal.sv
      - hw/ecc_lane.sv
      - hw/ecc_req_ctrl.sv
      - hw/ecc_err_collect.sv
      - hw/ecc_mem_top.sv
  - target: simulation
    files:
      - sim/tb_ecc_mem.sv

// ==== compile.f ====
hw/ecc_pkg.sv
hw/ecc_76_cal.sv
hw/ecc_lane.sv
hw/ecc_req_ctrl.sv
hw/ecc_err_collect.sv
hw/ecc_mem_top.sv
sim/tb_ecc_mem.sv

// ==== hw/ecc_76_cal.sv ====
`timescale 1ns/1ps

module ecc_76_cal (
    input  ecc_pkg::lane_data_t data_in,
    input  ecc_pkg::parity_t    parity_in,
    input  logic                bypass,
    output ecc_pkg::lane_data_t data_out,
    output logic                sbit_err,
    output logic                dbit_err
);

    import ecc_pkg::*;

    parity_t    syndrome;
    lane_data_t mask;
    logic       col_hit;
    logic       chk_bit_err;
    logic       single;
    logic       double;

    assign syndrome = parity_in ^ ecc_parity(data_in);

    // one-hot correction mask from the matching data column.
    always_comb begin
        mask = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (syndrome == ECC_COLS[i]) begin
                mask[i] = 1'b1;
            end
        end
    end

    assign col_hit = |mask;

    // weight one means a flipped check bit, data stays as stored.
    assign chk_bit_err = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);

    assign single = col_hit | chk_bit_err;
    assign double = (syndrome != '0) & ~single;

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = ~bypass & single;
    assign dbit_err = ~bypass & double;

    // at most one bit is ever corrected, and never alongside a double flag.
    always_comb begin
        assert final (!(sbit_err && dbit_err) && $onehot0(data_out ^ data_in))
            else $error("ecc_76_cal: conflicting flags or multi-bit correction");
    end

endmodule

// ==== hw/ecc_err_collect.sv ====
`timescale 1ns/1ps

module ecc_err_collect (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            clear,
    input  logic                            rd_valid_pipe,
    input  ecc_pkg::addr_t                  rd_addr_pipe,
    input  ecc_pkg::word_t                  lane_rdata,
    input  logic [ecc_pkg::LANE_COUNT-1:0]  lane_sbit,
    input  logic [ecc_pkg::LANE_COUNT-1:0]  lane_dbit,
    output logic                            rd_valid,
    output ecc_pkg::word_t                  rdata,
    output logic                            sbit_err,
    output logic                            dbit_err,
    output ecc_pkg::count_t                 corr_count,
    output ecc_pkg::count_t                 uncorr_count,
    output ecc_pkg::addr_t                  err_addr
);

    import ecc_pkg::*;

    logic dbit_any;
    logic sbit_any;

    // a double error anywhere masks the single flag.
    assign dbit_any = |lane_dbit;
    assign sbit_any = (|lane_sbit) & ~dbit_any;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid     <= 1'b0;
            sbit_err     <= 1'b0;
            dbit_err     <= 1'b0;
            corr_count   <= '0;
            uncorr_count <= '0;
            err_addr     <= '0;
        end else begin
            rd_valid <= rd_valid_pipe;
            sbit_err <= rd_valid_pipe & sbit_any;
            dbit_err <= rd_valid_pipe & dbit_any;
            // clear wins over a same-cycle error.
            if (clear) begin
                corr_count   <= '0;
                uncorr_count <= '0;
            end else begin
                if (rd_valid_pipe && sbit_any && corr_count != {CNT_WIDTH{1'b1}}) begin
                    corr_count <= corr_count + 1'b1;
                end
                if (rd_valid_pipe && dbit_any && uncorr_count != {CNT_WIDTH{1'b1}}) begin
                    uncorr_count <= uncorr_count + 1'b1;
                end
            end
            if (rd_valid_pipe && (sbit_any || dbit_any)) begin
                err_addr <= rd_addr_pipe;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid_pipe) begin
            rdata <= lane_rdata;
        end
    end

    a_valid_has_source: assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> $past(rd_valid_pipe))
        else $error("ecc_err_collect: rd_valid without pipe valid");

endmodule

// ==== hw/ecc_lane.sv ====
`timescale 1ns/1ps

module ecc_lane (
    input  logic                clk,
    input  logic                wr_en,
    input  logic                rd_en,
    input  ecc_pkg::addr_t      addr,
    input  ecc_pkg::lane_data_t wdata,
    input  ecc_pkg::lane_data_t inject,
    input  logic                bypass,
    output ecc_pkg::lane_data_t rdata,
    output logic                sbit,
    output logic                dbit
);

    import ecc_pkg::*;

    lane_data_t data_mem [2**ADDR_WIDTH];
    parity_t    par_mem  [2**ADDR_WIDTH];

    lane_data_t cw_data;
    parity_t    cw_par;
    lane_data_t chk_data;
    logic       chk_sbit;
    logic       chk_dbit;

    // check bits come from the clean data, so injected flips show up on read.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[addr] <= wdata ^ inject;
            par_mem[addr]  <= ecc_parity(wdata);
        end
        if (rd_en) begin
            cw_data <= data_mem[addr];
            cw_par  <= par_mem[addr];
        end
    end

    ecc_76_cal u_cal (
        .data_in   (cw_data),
        .parity_in (cw_par),
        .bypass    (bypass),
        .data_out  (chk_data),
        .sbit_err  (chk_sbit),
        .dbit_err  (chk_dbit)
    );

    // second read stage.
    always_ff @(posedge clk) begin
        rdata <= chk_data;
        sbit  <= chk_sbit;
        dbit  <= chk_dbit;
    end

    a_no_rw_collision: assert property (@(posedge clk)
        !(wr_en === 1'b1 && rd_en === 1'b1))
        else $error("ecc_lane: write and read strobes together");

endmodule

// ==== hw/ecc_mem_top.sv ====
`timescale 1ns/1ps

module ecc_mem_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            req,
    input  logic            we,
    input  ecc_pkg::addr_t  addr,
    input  ecc_pkg::word_t  wdata,
    input  ecc_pkg::word_t  inject,
    input  logic            bypass,
    input  logic            clear,
    output logic            rd_valid,
    output ecc_pkg::word_t  rdata,
    output logic            sbit_err,
    output logic            dbit_err,
    output ecc_pkg::count_t corr_count,
    output ecc_pkg::count_t uncorr_count,
    output ecc_pkg::addr_t  err_addr
);

    import ecc_pkg::*;

    logic                  wr_en;
    logic                  rd_en;
    addr_t                 lane_addr;
    word_t                 lane_wdata;
    word_t                 lane_inject;
    logic                  rd_valid_pipe;
    addr_t                 rd_addr_pipe;
    word_t                 lane_rdata;
    logic [LANE_COUNT-1:0] lane_sbit;
    logic [LANE_COUNT-1:0] lane_dbit;

    ecc_req_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .we            (we),
        .addr          (addr),
        .wdata         (wdata),
        .inject        (inject),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .lane_addr     (lane_addr),
        .lane_wdata    (lane_wdata),
        .lane_inject   (lane_inject),
        .rd_valid_pipe (rd_valid_pipe),
        .rd_addr_pipe  (rd_addr_pipe)
    );

    // lane i owns word bits 76*i upward.
    for (genvar i = 0; i < LANE_COUNT; i++) begin : g_lane
        ecc_lane u_lane (
            .clk    (clk),
            .wr_en  (wr_en),
            .rd_en  (rd_en),
            .addr   (lane_addr),
            .wdata  (lane_wdata[i*DATA_WIDTH +: DATA_WIDTH]),
            .inject (lane_inject[i*DATA_WIDTH +: DATA_WIDTH]),
            .bypass (bypass),
            .rdata  (lane_rdata[i*DATA_WIDTH +: DATA_WIDTH]),
            .sbit   (lane_sbit[i]),
            .dbit   (lane_dbit[i])
        );
    end

    ecc_err_collect u_collect (
        .clk           (clk),
        .reset         (reset),
        .clear         (clear),
        .rd_valid_pipe (rd_valid_pipe),
        .rd_addr_pipe  (rd_addr_pipe),
        .lane_rdata    (lane_rdata),
        .lane_sbit     (lane_sbit),
        .lane_dbit     (lane_dbit),
        .rd_valid      (rd_valid),
        .rdata         (rdata),
        .sbit_err      (sbit_err),
        .dbit_err      (dbit_err),
        .corr_count    (corr_count),
        .uncorr_count  (uncorr_count),
        .err_addr      (err_addr)
    );

endmodule

// ==== hw/ecc_pkg.sv ====
package ecc_pkg;

    localparam int LANE_COUNT   = 2;
    localparam int DATA_WIDTH   = 76;
    localparam int PARITY_WIDTH = 8;
    localparam int ADDR_WIDTH   = 6;
    localparam int CNT_WIDTH    = 16;

    typedef logic [DATA_WIDTH-1:0]            lane_data_t;
    typedef logic [PARITY_WIDTH-1:0]          parity_t;
    typedef logic [LANE_COUNT*DATA_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0]            addr_t;
    typedef logic [CNT_WIDTH-1:0]             count_t;

    // one check-bit column per data bit.
    typedef logic [DATA_WIDTH-1:0][PARITY_WIDTH-1:0] col_table_t;

    // hamming positions skip the powers of two; the top bit makes every
    // column odd weight.
    function automatic col_table_t ecc_columns();
        col_table_t                tbl;
        logic [PARITY_WIDTH-2:0]   pos;
        int                        idx;
        int                        n;
        tbl = '0;
        idx = 0;
        for (n = 3; n < 2**(PARITY_WIDTH-1); n++) begin
            pos = (PARITY_WIDTH-1)'(n);
            if (idx < DATA_WIDTH && (pos & (pos - 1'b1)) != '0) begin
                tbl[idx] = {~^pos, pos};
                idx++;
            end
        end
        return tbl;
    endfunction

    localparam col_table_t ECC_COLS = ecc_columns();

    // check bits of one lane.
    function automatic parity_t ecc_parity(input lane_data_t d);
        parity_t p;
        int      i;
        p = '0;
        for (i = 0; i < DATA_WIDTH; i++) begin
            if (d[i]) begin
                p = p ^ ECC_COLS[i];
            end
        end
        return p;
    endfunction

endpackage

// ==== hw/ecc_req_ctrl.sv ====
`timescale 1ns/1ps

module ecc_req_ctrl (
    input  logic           clk,
    input  logic           reset,
    input  logic           req,
    input  logic           we,
    input  ecc_pkg::addr_t addr,
    input  ecc_pkg::word_t wdata,
    input  ecc_pkg::word_t inject,
    output logic           wr_en,
    output logic           rd_en,
    output ecc_pkg::addr_t lane_addr,
    output ecc_pkg::word_t lane_wdata,
    output ecc_pkg::word_t lane_inject,
    output logic           rd_valid_pipe,
    output ecc_pkg::addr_t rd_addr_pipe
);

    import ecc_pkg::*;

    logic  rd_valid_s1;
    addr_t rd_addr_s1;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en         <= 1'b0;
            rd_en         <= 1'b0;
            rd_valid_s1   <= 1'b0;
            rd_valid_pipe <= 1'b0;
        end else begin
            wr_en         <= req & we;
            rd_en         <= req & ~we;
            rd_valid_s1   <= rd_en;
            rd_valid_pipe <= rd_valid_s1;
        end
    end

    // payload follows the strobes.
    always_ff @(posedge clk) begin
        lane_addr    <= addr;
        lane_wdata   <= wdata;
        lane_inject  <= inject;
        rd_addr_s1   <= lane_addr;
        rd_addr_pipe <= rd_addr_s1;
    end

    a_req_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(req))
        else $error("ecc_req_ctrl: req unknown");

    a_req_fields_known: assert property (@(posedge clk) disable iff (reset)
        req |-> !$isunknown({we, addr}))
        else $error("ecc_req_ctrl: request fields unknown");

endmodule

// ==== sim/tb_ecc_mem.sv ====
`timescale 1ns/1ps

module tb_ecc_mem;

    import ecc_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int READ_LATENCY = 3;
    // requests issued by all tests together.
    localparam int REQ_COUNT    = 163;

    logic            clk;
    logic            reset;
    logic            req;
    logic            we;
    addr_t           addr;
    word_t           wdata;
    word_t           inject;
    logic            bypass;
    logic            clear;
    logic            rd_valid;
    word_t           rdata;
    logic            sbit_err;
    logic            dbit_err;
    count_t          corr_count;
    count_t          uncorr_count;
    addr_t           err_addr;

    // stored words and the inject pattern they were written with.
    word_t           model_mem [2**ADDR_WIDTH];
    word_t           model_inj [2**ADDR_WIDTH];
    count_t          model_corr;
    count_t          model_uncorr;
    addr_t           model_err_addr;
    logic [31:0]     lfsr_state;
    int              cycle_count;

    word_t           exp_data_q [$];
    logic            exp_sbit_q [$];
    logic            exp_dbit_q [$];
    addr_t           exp_addr_q [$];
    int              exp_edge_q [$];

    ecc_mem_top uut (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .we           (we),
        .addr         (addr),
        .wdata        (wdata),
        .inject       (inject),
        .bypass       (bypass),
        .clear        (clear),
        .rd_valid     (rd_valid),
        .rdata        (rdata),
        .sbit_err     (sbit_err),
        .dbit_err     (dbit_err),
        .corr_count   (corr_count),
        .uncorr_count (uncorr_count),
        .err_addr     (err_addr)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output word_t w);
        int i;
        for (i = 0; i < LANE_COUNT*DATA_WIDTH; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[i] = lfsr_state[0];
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            fail_run($sformatf("Error: time %0t: %s expected %h, got %h", $time, name, want, got));
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t want);
        if (got !== want) begin
            fail_run($sformatf("Error: time %0t: %s expected %0d, got %0d", $time, name, want, got));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t want);
        if (got !== want) begin
            fail_run($sformatf("Error: time %0t: %s expected %0d, got %0d", $time, name, want, got));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            fail_run($sformatf("Error: time %0t: %s expected %b, got %b", $time, name, want, got));
        end
    endtask

    task automatic issue_write(input addr_t a, input word_t d, input word_t inj);
        @(negedge clk);
        req    = 1'b1;
        we     = 1'b1;
        addr   = a;
        wdata  = d;
        inject = inj;
        model_mem[a] = d ^ inj;
        model_inj[a] = inj;
    endtask

    // expected result follows from the inject weight of each lane.
    task automatic issue_read(input addr_t a);
        word_t      want;
        logic       sb;
        logic       db;
        lane_data_t inj_l;
        int         l;
        @(negedge clk);
        req    = 1'b1;
        we     = 1'b0;
        addr   = a;
        wdata  = '0;
        inject = '0;
        want = model_mem[a];
        sb = 1'b0;
        db = 1'b0;
        if (!bypass) begin
            for (l = 0; l < LANE_COUNT; l++) begin
                inj_l = model_inj[a][l*DATA_WIDTH +: DATA_WIDTH];
                if ($countones(inj_l) == 1) begin
                    want[l*DATA_WIDTH +: DATA_WIDTH] = want[l*DATA_WIDTH +: DATA_WIDTH] ^ inj_l;
                    sb = 1'b1;
                end else if ($countones(inj_l) == 2) begin
                    db = 1'b1;
                end
            end
        end
        exp_data_q.push_back(want);
        exp_sbit_q.push_back(sb & ~db);
        exp_dbit_q.push_back(db);
        exp_addr_q.push_back(a);
        exp_edge_q.push_back(cycle_count + 1);
    endtask

    task automatic go_idle();
        @(negedge clk);
        req    = 1'b0;
        we     = 1'b0;
        wdata  = '0;
        inject = '0;
    endtask

    // queue only changes on falling edges, so poll on rising ones.
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_data_q.size() != 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (exp_data_q.size() != 0) begin
            fail_run("read responses did not come back within 20 cycles");
        end
        @(negedge clk);
    endtask

    always @(negedge clk) begin : response_monitor
        word_t want;
        logic  sb;
        logic  db;
        addr_t a;
        int    e0;
        if (reset === 1'b0) begin
            if ($isunknown(rd_valid)) begin
                fail_run("rd_valid is unknown after reset");
            end else if (rd_valid) begin
                if (exp_data_q.size() == 0) begin
                    fail_run("rd_valid came without a pending read");
                end else begin
                    want = exp_data_q.pop_front();
                    sb   = exp_sbit_q.pop_front();
                    db   = exp_dbit_q.pop_front();
                    a    = exp_addr_q.pop_front();
                    e0   = exp_edge_q.pop_front();
                    if (cycle_count != e0 + READ_LATENCY) begin
                        fail_run($sformatf("Error: time %0t: read latency expected %0d, got %0d",
                            $time, READ_LATENCY, cycle_count - e0));
                    end
                    if (sb) model_corr = model_corr + 1'b1;
                    if (db) model_uncorr = model_uncorr + 1'b1;
                    if (sb || db) model_err_addr = a;
                    check_word("rdata", rdata, want);
                    check_flag("sbit_err", sbit_err, sb);
                    check_flag("dbit_err", dbit_err, db);
                    check_count("corr_count", corr_count, model_corr);
                    check_count("uncorr_count", uncorr_count, model_uncorr);
                    check_addr("err_addr", err_addr, model_err_addr);
                end
            end
        end
    end

    task automatic test_clean_round_trip();
        word_t d;
        int    i;
        for (i = 0; i < 2**ADDR_WIDTH; i++) begin
            random_word(d);
            issue_write(addr_t'(i), d, '0);
        end
        for (i = 0; i < 2**ADDR_WIDTH; i++) begin
            issue_read(addr_t'(i));
        end
        go_idle();
        wait_drain();
        check_count("corr_count", corr_count, '0);
        check_count("uncorr_count", uncorr_count, '0);
    endtask

    // low, middle and top bit of each lane.
    task automatic test_single_correction();
        word_t d;
        int    lane;
        int    k;
        int    n;
        int    pos;
        n = 0;
        for (lane = 0; lane < LANE_COUNT; lane++) begin
            for (k = 0; k < 3; k++) begin
                pos = (k == 0) ? 0 : (k == 1) ? DATA_WIDTH/2 : DATA_WIDTH-1;
                random_word(d);
                issue_write(addr_t'(n), d, word_t'(1) << (lane*DATA_WIDTH + pos));
                n++;
            end
        end
        for (k = 0; k < n; k++) begin
            issue_read(addr_t'(k));
        end
        go_idle();
        wait_drain();
        check_count("corr_count", corr_count, count_t'(6));
        check_addr("err_addr", err_addr, addr_t'(5));
    endtask

    task automatic test_double_detection();
        word_t d;
        random_word(d);
        issue_write(addr_t'(10), d,
            (word_t'(1) << (DATA_WIDTH+3)) | (word_t'(1) << (DATA_WIDTH+50)));
        // double in lane 0 hides the single in lane 1.
        random_word(d);
        issue_write(addr_t'(11), d,
            (word_t'(1) << 10) | (word_t'(1) << 70) | (word_t'(1) << (DATA_WIDTH+20)));
        issue_read(addr_t'(10));
        issue_read(addr_t'(11));
        go_idle();
        wait_drain();
        check_count("uncorr_count", uncorr_count, count_t'(2));
        check_count("corr_count", corr_count, count_t'(6));
        check_addr("err_addr", err_addr, addr_t'(11));
    endtask

    task automatic test_bypass_read();
        int i;
        bypass = 1'b1;
        for (i = 0; i < 6; i++) begin
            issue_read(addr_t'(i));
        end
        issue_read(addr_t'(10));
        issue_read(addr_t'(11));
        go_idle();
        wait_drain();
        bypass = 1'b0;
        // still what the correction and detection tests left.
        check_count("corr_count", corr_count, count_t'(6));
        check_count("uncorr_count", uncorr_count, count_t'(2));
        check_addr("err_addr", err_addr, addr_t'(11));
    endtask

    task automatic test_pipelined_reads();
        word_t d;
        int    i;
        random_word(d);
        issue_write(addr_t'(30), d, '0);
        issue_read(addr_t'(30));
        for (i = 20; i < 27; i++) begin
            issue_read(addr_t'(i));
        end
        go_idle();
        wait_drain();
    endtask

    task automatic test_counter_clear();
        word_t d;
        clear = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        model_corr   = '0;
        model_uncorr = '0;
        check_count("corr_count", corr_count, '0);
        check_count("uncorr_count", uncorr_count, '0);
        random_word(d);
        issue_write(addr_t'(40), d, word_t'(1) << 100);
        issue_read(addr_t'(40));
        go_idle();
        wait_drain();
        check_count("corr_count", corr_count, count_t'(1));
        check_count("uncorr_count", uncorr_count, '0);
        check_addr("err_addr", err_addr, addr_t'(40));
    endtask

    initial begin : watchdog
        #(CLK_PERIOD * (RESET_CYCLES + REQ_COUNT*10));
        fail_run("watchdog expired before the tests finished");
    end

    initial begin
        clk    = 1'b0;
        reset  = 1'b1;
        req    = 1'b0;
        we     = 1'b0;
        addr   = '0;
        wdata  = '0;
        inject = '0;
        bypass = 1'b0;
        clear  = 1'b0;
        lfsr_state     = 32'h8a6bf14e;
        cycle_count    = 0;
        model_corr     = '0;
        model_uncorr   = '0;
        model_err_addr = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        check_flag("rd_valid", rd_valid, 1'b0);
        check_count("corr_count", corr_count, '0);
        check_count("uncorr_count", uncorr_count, '0);
        check_addr("err_addr", err_addr, '0);

        test_clean_round_trip();
        test_single_correction();
        test_double_detection();
        test_bypass_read();
        test_pipelined_reads();
        test_counter_clear();

        $display("All tests passed");
        $finish;
    end

endmodule
